// ==== source/rom_loader_pkg.sv ====
/*
 * ROM loader shared definitions
 * Bus widths, reset counter limits and the FSM state encodings
 */

package rom_loader_pkg;

	//////////////////////////////////////////////////////////////////////
	// Host download port
	//////////////////////////////////////////////////////////////////////

	// Byte address from the host
	localparam int host_addr_width = 25;
	// One host word per write strobe
	localparam int host_data_width = 16;

	//////////////////////////////////////////////////////////////////////
	// Wishbone side
	//////////////////////////////////////////////////////////////////////

	// Two host words per bus word
	localparam int bus_data_width = 32;
	// Word address, byte address divided by four
	localparam int bus_addr_width = host_addr_width - 2;

	//////////////////////////////////////////////////////////////////////
	// Reset counters and input registers
	//////////////////////////////////////////////////////////////////////

	localparam int reset_count_width = 8;
	// Both counters stop here
	localparam logic [reset_count_width-1:0] reset_count_final = 8'd255;

	// Register stages on host data and address
	// The strobe runs one stage deeper for the edge detect
	localparam int sync_stages = 2;

	// Packer FSM
	typedef enum logic [1:0] {
		collect_low,
		collect_high,
		bus_write
	} pack_state_t;

	// Download hold FSM
	typedef enum logic [1:0] {
		hold_armed,
		hold_counting,
		hold_done
	} hold_state_t;

endpackage

// ==== source/ioctl_synchronizer.sv ====
/*
 * Host port input registers
 * Brings the download port into system_clock and flags each write strobe
 */

`timescale 1ns/1ns

module ioctl_synchronizer (
	input  logic                                        system_clock,
	input  logic                                        hardware_reset,
	input  logic                                        ioctl_download,
	input  logic                                        ioctl_wr,
	input  logic [rom_loader_pkg::host_addr_width-1:0]  ioctl_addr,
	input  logic [rom_loader_pkg::host_data_width-1:0]  ioctl_dout,
	output logic                                        sync_download,
	output logic                                        write_edge,
	output logic [rom_loader_pkg::host_addr_width-1:0]  sync_addr,
	output logic [rom_loader_pkg::host_data_width-1:0]  sync_data
);

	import rom_loader_pkg::*;

	// Strobe history with the newest sample in bit 0
	logic [sync_stages:0] wr_stage;

	// Payload pipelines with the first stage at index 0
	logic [host_data_width-1:0] data_stage [sync_stages];
	logic [host_addr_width-1:0] addr_stage [sync_stages];

	//////////////////////////////////////////////////////////////////////
	// Control registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge system_clock) begin
		if (hardware_reset) begin
			wr_stage      <= '0;
			sync_download <= 1'b0;
		end else begin
			wr_stage      <= {wr_stage[sync_stages-1:0], ioctl_wr};
			// Download level lags the pin by one clock
			sync_download <= ioctl_download;
		end
	end

	// Data and address move along with the strobe
	always_ff @(posedge system_clock) begin
		data_stage[0] <= ioctl_dout;
		addr_stage[0] <= ioctl_addr;
		for (int i = 1; i < sync_stages; i++) begin
			data_stage[i] <= data_stage[i-1];
			addr_stage[i] <= addr_stage[i-1];
		end
	end

	// Low then high in the two oldest strobe samples
	// Lines up with the data sampled with the first high strobe
	assign write_edge = wr_stage[sync_stages-1] & ~wr_stage[sync_stages];

	assign sync_data = data_stage[sync_stages-1];
	assign sync_addr = addr_stage[sync_stages-1];

endmodule

// ==== source/reset_sequencer.sv ====
/*
 * Reset sequencer
 * Holds the host at the start of a download, then holds system_reset after it
 */

`timescale 1ns/1ns

module reset_sequencer (
	input  logic system_clock,
	input  logic hardware_reset,
	input  logic sync_download,
	output logic hold_wait,
	output logic system_reset
);

	import rom_loader_pkg::*;

	hold_state_t hold_state;

	// Download hold count
	logic [reset_count_width-1:0] hold_count;
	// Post download system reset count
	logic [reset_count_width-1:0] system_count;

	logic hold_active;
	logic system_count_done;

	assign hold_active       = (hold_state == hold_counting);
	assign system_count_done = (system_count == reset_count_final);

	//////////////////////////////////////////////////////////////////////
	// Download hold FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge system_clock) begin
		if (hardware_reset) begin
			hold_state <= hold_armed;
			hold_count <= '0;
		end else begin
			case (hold_state)
				hold_armed: begin
					// First download cycle starts the hold
					hold_count <= '0;
					if (sync_download) begin
						hold_state <= hold_counting;
					end
				end
				hold_counting: begin
					if (hold_count != reset_count_final) begin
						hold_count <= hold_count + 1'b1;
					end else begin
						// Count complete, release the host
						hold_state <= hold_done;
					end
				end
				hold_done: begin
					// Re-arm once the system reset has run out
					if (system_count_done) begin
						hold_state <= hold_armed;
					end
				end
				default: begin
					hold_state <= hold_armed;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// System reset counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge system_clock) begin
		if (hardware_reset) begin
			system_count <= '0;
		end else if (sync_download || hold_active) begin
			// Kept at zero through the download and its hold
			system_count <= '0;
		end else if (!system_count_done) begin
			system_count <= system_count + 1'b1;
		end
	end

	// Host waits for the whole hold count
	assign hold_wait = hold_active;

	// Released once the counter reaches its limit
	assign system_reset = !system_count_done;

endmodule

// ==== source/word_packer.sv ====
/*
 * Word packer
 * Joins pairs of host words and writes each one out as a Wishbone classic write
 */

`timescale 1ns/1ns

module word_packer (
	input  logic                                        system_clock,
	input  logic                                        hardware_reset,
	input  logic                                        sync_download,
	input  logic                                        write_edge,
	input  logic [rom_loader_pkg::host_addr_width-1:0]  sync_addr,
	input  logic [rom_loader_pkg::host_data_width-1:0]  sync_data,
	output logic                                        wb_cyc,
	output logic [rom_loader_pkg::bus_addr_width-1:0]   wb_adr,
	output logic [rom_loader_pkg::bus_data_width-1:0]   wb_dat,
	input  logic                                        wb_ack,
	output logic                                        pack_wait
);

	import rom_loader_pkg::*;

	pack_state_t pack_state;

	// Half selects within the bus word
	localparam int low_top  = host_data_width - 1;
	localparam int high_top = bus_data_width - 1;

	logic take_low;
	logic take_high;

	// Strobes only count while the download is on
	assign take_low  = sync_download && write_edge && (pack_state == collect_low);
	assign take_high = sync_download && write_edge && (pack_state == collect_high);

	//////////////////////////////////////////////////////////////////////
	// Packer FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge system_clock) begin
		if (hardware_reset) begin
			pack_state <= collect_low;
		end else if (!sync_download) begin
			// Download ended, abandon any half word or transfer
			pack_state <= collect_low;
		end else begin
			case (pack_state)
				collect_low: begin
					if (write_edge) begin
						pack_state <= collect_high;
					end
				end
				collect_high: begin
					// Second half completes the word
					if (write_edge) begin
						pack_state <= bus_write;
					end
				end
				bus_write: begin
					// Strobes are ignored here, the host is stopped
					if (wb_ack) begin
						pack_state <= collect_low;
					end
				end
				default: begin
					pack_state <= collect_low;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bus word and address
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge system_clock) begin
		if (take_low) begin
			wb_dat[low_top:0] <= sync_data;
			// Byte address of the first half, divided by four
			wb_adr <= sync_addr[host_addr_width-1:2];
		end
		if (take_high) begin
			wb_dat[high_top:host_data_width] <= sync_data;
		end
	end

	// One classic write, held until acknowledged
	assign wb_cyc = (pack_state == bus_write);

	// Host stays stopped for the whole transfer
	assign pack_wait = wb_cyc;

endmodule

// ==== source/rom_loader.sv ====
/*
 * ROM loader top level
 * Host download port in, Wishbone writes and the system reset out
 */

`timescale 1ns/1ns

module rom_loader (
	input  logic                                        system_clock,
	input  logic                                        hardware_reset,
	input  logic                                        ioctl_download,
	input  logic                                        ioctl_wr,
	input  logic [rom_loader_pkg::host_addr_width-1:0]  ioctl_addr,
	input  logic [rom_loader_pkg::host_data_width-1:0]  ioctl_dout,
	output logic                                        ioctl_wait,
	output logic                                        wb_cyc,
	output logic [rom_loader_pkg::bus_addr_width-1:0]   wb_adr,
	output logic [rom_loader_pkg::bus_data_width-1:0]   wb_dat,
	input  logic                                        wb_ack,
	output logic                                        system_reset
);

	import rom_loader_pkg::*;

	// Registered host port
	logic                       sync_download;
	logic                       write_edge;
	logic [host_addr_width-1:0] sync_addr;
	logic [host_data_width-1:0] sync_data;

	// Wait requests from the packer and the sequencer
	logic pack_wait;
	logic hold_wait;

	//////////////////////////////////////////////////////////////////////
	// Host input registers
	//////////////////////////////////////////////////////////////////////

	ioctl_synchronizer u_ioctl_synchronizer (
		.system_clock   (system_clock),
		.hardware_reset (hardware_reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.sync_download  (sync_download),
		.write_edge     (write_edge),
		.sync_addr      (sync_addr),
		.sync_data      (sync_data)
	);

	// Two host words per Wishbone write
	word_packer u_word_packer (
		.system_clock   (system_clock),
		.hardware_reset (hardware_reset),
		.sync_download  (sync_download),
		.write_edge     (write_edge),
		.sync_addr      (sync_addr),
		.sync_data      (sync_data),
		.wb_cyc         (wb_cyc),
		.wb_adr         (wb_adr),
		.wb_dat         (wb_dat),
		.wb_ack         (wb_ack),
		.pack_wait      (pack_wait)
	);

	// Download hold and system reset
	reset_sequencer u_reset_sequencer (
		.system_clock   (system_clock),
		.hardware_reset (hardware_reset),
		.sync_download  (sync_download),
		.hold_wait      (hold_wait),
		.system_reset   (system_reset)
	);

	// Either block can stop the host
	assign ioctl_wait = pack_wait | hold_wait;

endmodule

// ==== testbench/rom_loader_tb.sv ====
/*
 * ROM loader testbench
 * Table-driven host downloads against a Wishbone memory model with random acknowledge
 */

`timescale 1ns/1ns

module rom_loader_tb;

	import rom_loader_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	localparam int table_length = 12;
	// Entries before this index form the first download
	localparam int first_length = 8;
	localparam int word_count = table_length / 2;
	localparam int watchdog_cycles = table_length * 40 + 2000;

	// Low half at byte address 4k and high half at 4k+2
	localparam logic [host_addr_width-1:0] table_addr [table_length] = '{
		25'h000000, 25'h000002, 25'h000004, 25'h000006,
		25'h000008, 25'h00000a, 25'h00000c, 25'h00000e,
		25'h000100, 25'h000102, 25'h000104, 25'h000106
	};
	localparam logic [host_data_width-1:0] table_data [table_length] = '{
		16'h1234, 16'hbeef, 16'h0001, 16'h8000,
		16'hffff, 16'h0000, 16'ha5a5, 16'h5a5a,
		16'hcafe, 16'hf00d, 16'h7e57, 16'h0c0d
	};

	logic                       system_clock;
	logic                       hardware_reset;
	logic                       ioctl_download;
	logic                       ioctl_wr;
	logic [host_addr_width-1:0] ioctl_addr;
	logic [host_data_width-1:0] ioctl_dout;
	logic                       ioctl_wait;
	logic                       wb_cyc;
	logic [bus_addr_width-1:0]  wb_adr;
	logic [bus_data_width-1:0]  wb_dat;
	logic                       wb_ack = 1'b0;
	logic                       system_reset;

	integer seed = 32'hd4668891;

	// Expected bus words in table order
	logic [bus_addr_width-1:0] expected_adr [word_count];
	logic [bus_data_width-1:0] expected_dat [word_count];
	int write_index = 0;

	// Memory model state
	logic [bus_data_width-1:0] memory [256];
	logic [bus_addr_width-1:0] held_adr;
	logic [bus_data_width-1:0] held_dat;
	logic in_transfer;
	logic ack_seen;
	int ack_delay;

	rom_loader u_rom_loader (
		.system_clock   (system_clock),
		.hardware_reset (hardware_reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.wb_cyc         (wb_cyc),
		.wb_adr         (wb_adr),
		.wb_dat         (wb_dat),
		.wb_ack         (wb_ack),
		.system_reset   (system_reset)
	);

	initial begin
		system_clock = 1'b0;
		forever #50 system_clock = ~system_clock;
	end

	//////////////////////////////////////////////////////////////////////
	// Failure handling and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_signal(input logic got, input logic want, input string what);
		if (got !== want) begin
			$display("[FAIL] %0t ns %s: got %b expected %b", $time, what, got, want);
			stop_run();
		end
	endtask

	task automatic check_count(input int got, input int want, input string what);
		if (got != want) begin
			$display("[FAIL] %0t ns %s: got %0d expected %0d", $time, what, got, want);
			stop_run();
		end
	endtask

	task automatic check_word(
		input logic [bus_addr_width-1:0] got_adr,
		input logic [bus_data_width-1:0] got_dat,
		input logic [bus_addr_width-1:0] want_adr,
		input logic [bus_data_width-1:0] want_dat,
		input string what
	);
		if (got_adr !== want_adr || got_dat !== want_dat) begin
			$display("[FAIL] %0t ns %s: got %h:%h expected %h:%h",
				$time, what, got_adr, got_dat, want_adr, want_dat);
			stop_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Wishbone memory model
	//////////////////////////////////////////////////////////////////////

	always @(posedge system_clock) begin
		if (hardware_reset) begin
			wb_ack <= 1'b0;
			in_transfer = 1'b0;
			ack_seen = 1'b0;
		end else begin
			// Cycle ends on the clock that samples the ack
			if (ack_seen) begin
				check_signal(wb_cyc, 1'b0, "wb_cyc one clock after wb_ack");
				ack_seen = 1'b0;
			end
			if (wb_cyc) begin
				if (!in_transfer) begin
					in_transfer = 1'b1;
					held_adr = wb_adr;
					held_dat = wb_dat;
					ack_delay = int'($unsigned($random(seed)) % 5);
				end
				check_word(wb_adr, wb_dat, held_adr, held_dat, "bus word stable in cycle");
				check_signal(ioctl_wait, 1'b1, "ioctl_wait during bus write");
			end
			if (wb_ack) begin
				check_signal(wb_cyc, 1'b1, "wb_cyc while wb_ack high");
				wb_ack <= 1'b0;
				if (write_index >= word_count) begin
					$display("Unexpected Wishbone write at %0t ns after the last table word", $time);
					stop_run();
				end
				check_word(held_adr, held_dat, expected_adr[write_index],
					expected_dat[write_index], "Wishbone write");
				memory[held_adr[7:0]] = held_dat;
				write_index = write_index + 1;
				in_transfer = 1'b0;
				ack_seen = 1'b1;
			end else if (wb_cyc) begin
				if (ack_delay == 0) begin
					wb_ack <= 1'b1;
				end else begin
					ack_delay = ack_delay - 1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Host model
	//////////////////////////////////////////////////////////////////////

	task automatic write_host_word(
		input logic [host_addr_width-1:0] addr,
		input logic [host_data_width-1:0] data
	);
		int strobe_cycles;
		begin
			// No new strobe while the loader holds the host
			@(negedge system_clock);
			while (ioctl_wait) begin
				@(negedge system_clock);
			end
			strobe_cycles = int'($unsigned($random(seed)) % 3) + 1;
			@(posedge system_clock);
			ioctl_addr <= addr;
			ioctl_dout <= data;
			ioctl_wr   <= 1'b1;
			repeat (strobe_cycles) @(posedge system_clock);
			ioctl_wr <= 1'b0;
			// Strobe needs three clocks to reach the packer
			repeat (3) @(posedge system_clock);
		end
	endtask

	task automatic run_download(input int first, input int last);
		int wait_cycles;
		int hold_cycles;
		int reset_cycles;
		begin
			@(posedge system_clock);
			ioctl_download <= 1'b1;
			wait_cycles = 0;
			do begin
				@(negedge system_clock);
				wait_cycles++;
			end while (!ioctl_wait && wait_cycles < 4);
			check_signal(ioctl_wait, 1'b1, "ioctl_wait at download start");
			// Hold is the full count plus the release clock
			hold_cycles = 0;
			while (ioctl_wait) begin
				check_signal(wb_cyc, 1'b0, "wb_cyc during download hold");
				hold_cycles++;
				@(negedge system_clock);
			end
			check_count(hold_cycles, int'(reset_count_final) + 1, "download hold length");
			for (int i = first; i <= last; i++) begin
				write_host_word(table_addr[i], table_data[i]);
			end
			// Let the last bus write finish
			@(negedge system_clock);
			while (ioctl_wait) begin
				@(negedge system_clock);
			end
			check_count(write_index, (last + 1) / 2, "Wishbone writes so far");
			@(posedge system_clock);
			ioctl_download <= 1'b0;
			// One register stage before the counter sees the end
			@(posedge system_clock);
			reset_cycles = 0;
			@(negedge system_clock);
			while (system_reset) begin
				reset_cycles++;
				@(negedge system_clock);
			end
			check_count(reset_cycles, int'(reset_count_final), "system_reset after download");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		hardware_reset <= 1'b1;
		ioctl_download <= 1'b0;
		ioctl_wr       <= 1'b0;
		ioctl_addr     <= '0;
		ioctl_dout     <= '0;
		// High half from the odd entry, address from the even entry
		for (int k = 0; k < word_count; k++) begin
			expected_adr[k] = table_addr[2*k][host_addr_width-1:2];
			expected_dat[k] = {table_data[2*k+1], table_data[2*k]};
		end
		repeat (3) @(posedge system_clock);
		hardware_reset <= 1'b0;
		@(negedge system_clock);
		check_signal(wb_cyc, 1'b0, "wb_cyc after reset");
		check_signal(ioctl_wait, 1'b0, "ioctl_wait after reset");
		check_signal(system_reset, 1'b1, "system_reset after reset");
		run_download(0, first_length - 1);
		run_download(first_length, table_length - 1);
		for (int k = 0; k < word_count; k++) begin
			check_word(expected_adr[k], memory[expected_adr[k][7:0]],
				expected_adr[k], expected_dat[k], "memory contents");
		end
		if (write_index == word_count) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("Run ended after %0d of %0d Wishbone writes", write_index, word_count);
			stop_run();
		end
	end

	// Watchdog sized from the table length
	initial begin
		repeat (watchdog_cycles) @(posedge system_clock);
		$display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
		stop_run();
	end

endmodule

// ==== verilog.f ====
source/rom_loader_pkg.sv
source/ioctl_synchronizer.sv
source/reset_sequencer.sv
source/word_packer.sv
source/rom_loader.sv
testbench/rom_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ROM loader testbench with Verilator and runs it
# The log is searched for the failure line to decide the result

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ns \
	--top-module rom_loader_tb -Mdir "$build_dir" -f verilog.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

"./$build_dir/Vrom_loader_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "=== FAIL ===" "$log_file"; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
